/* Makefile */
# Verilator build and run of the mesh router testbench
SRCS := $(wildcard verilog/*.sv dv/*.sv include/*.svh)

.PHONY: all run clean

all: run

obj_dir/Vmesh_router_tb: $(SRCS) src.f
	verilator --binary --timing -j 0 --top-module mesh_router_tb \
		-f src.f -o Vmesh_router_tb

# Result is taken from the log, not from the exit status
run: obj_dir/Vmesh_router_tb
	./obj_dir/Vmesh_router_tb > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* include/router_model.svh */
// ##################################################
// Reference model for the router testbench, XY routing only
// Include inside a module that imports both packages
// ##################################################
`ifndef router_model_svh
`define router_model_svh

// One expected flit, tagged with its input and send cycle
typedef struct packed {
	flit_t flit;
	int    in_port;
	int    sent_cycle;
} exp_entry_t;

// Expected flits of one output, oldest first
typedef exp_entry_t exp_queue_t[$];

// Output port a flit should leave on under XY routing
function automatic port_t expected_port(input router_id_t id, input coord_t row,
	input coord_t col);
	coord_t own_row;
	coord_t own_col;
	own_row = id[3:2];
	own_col = id[1:0];
	// Column is settled first
	if (col < own_col)
		return port_west;
	if (col > own_col)
		return port_east;
	// Then the row, north is the smaller row
	if (row < own_row)
		return port_north;
	if (row > own_row)
		return port_south;
	return port_local;
endfunction

// Source field carries the input number, so outputs can be traced back
function automatic flit_t make_flit(input int in_port, input coord_t row, input coord_t col);
	flit_t f;
	f.dest_row = row;
	f.dest_col = col;
	f.source   = source_t'(in_port);
	f.payload  = payload_t'($urandom);
	return f;
endfunction

`endif

/* dv/mesh_router_tb.sv */
// ##################################################
// Testbench for the router at row 1, column 1, XY routing, depth 4
// Senders honour full_out, so no flit is dropped at an input
// ##################################################
`timescale 1ns/1ps

module mesh_router_tb
	import router_cfg_pkg::*;
	import flit_pkg::*;
();

	`include "router_model.svh"

	localparam router_id_t router_id = 4'd5;
	// 400 cycles for each of the five tests, plus margin
	localparam int timeout_cycles = 5 * 400 + 200;
	// Longest wait for the outputs to drain after a test
	localparam int drain_cycles = 200;

	logic       clk;
	logic       reset;
	flit_bus_t  flit_in;
	port_mask_t valid_in;
	port_mask_t full_out;
	flit_bus_t  flit_out;
	port_mask_t valid_out;
	port_mask_t full_in;

	// Scoreboard with one queue per output
	exp_queue_t sb [num_ports];
	int cycle = 0;
	int errors = 0;
	int test_errors = 0;
	int passed = 0;
	int failed = 0;
	// Output that must stay silent or -1 for none
	int held_port = -1;
	bit latency_check = 1'b0;
	bit traffic_done;

	mesh_router #(
		.buffer_depth(4),
		.route_alg   (route_xy)
	) mesh_router_i (
		.clk      (clk),
		.reset    (reset),
		.router_id(router_id),
		.flit_in  (flit_in),
		.valid_in (valid_in),
		.full_out (full_out),
		.flit_out (flit_out),
		.valid_out(valid_out),
		.full_in  (full_in)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Cycle count that also limits the run
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= timeout_cycles) begin
			$display("timeout: run stopped after %0d cycles without finishing", cycle);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// ##################################################
	// Helpers
	task automatic note_failure(input string msg);
		$display("%s, at %0t ns", msg, $time);
		errors++;
		test_errors++;
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			errors++;
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0)
			passed++;
		else
			failed++;
		$display("test %s finished with %0d errors", name, test_errors);
		test_errors = 0;
	endtask

	// Waits for room, drives one cycle, then idles one so full_out is current
	task automatic send_flit(input int p, input flit_t f);
		exp_entry_t e;
		@(negedge clk);
		while (full_out[p])
			@(negedge clk);
		@(posedge clk);
		flit_in[p]  <= f;
		valid_in[p] <= 1'b1;
		@(negedge clk);
		e.flit       = f;
		e.in_port    = p;
		e.sent_cycle = cycle;
		sb[expected_port(router_id, f.dest_row, f.dest_col)].push_back(e);
		@(posedge clk);
		valid_in[p] <= 1'b0;
	endtask

	// Random mode picks columns and gaps, else all go to one column
	task automatic send_stream(input int p, input int n, input bit rnd, input coord_t col);
		for (int j = 0; j < n; j++) begin
			if (rnd)
				repeat ($urandom % 3) @(posedge clk);
			send_flit(p, make_flit(p, coord_t'($urandom), rnd ? coord_t'($urandom) : col));
		end
	endtask

	// Until every expected flit is seen or the drain limit runs out
	// A few more cycles catch strays, then nothing may be left over
	task automatic wait_drain();
		int pending;
		int waited;
		pending = 1;
		waited  = 0;
		while (pending != 0 && waited < drain_cycles) begin
			@(negedge clk);
			waited++;
			pending = 0;
			for (int o = 0; o < num_ports; o++)
				pending += sb[o].size();
		end
		repeat (3) @(negedge clk);
		for (int o = 0; o < num_ports; o++) begin
			check_value("flits left in scoreboard", 32'(sb[o].size()), 32'd0);
			sb[o].delete();
		end
	endtask

	// ##################################################
	// Output comparison
	// Order is kept per input, so match the oldest entry of that input
	always @(negedge clk) begin : compare_outputs
		int    idx;
		flit_t got;
		if (!reset) begin
			for (int o = 0; o < num_ports; o++) begin
				if (valid_out[o]) begin
					got = flit_out[o];
					if (o == held_port)
						note_failure($sformatf("flit left output %0d while held full", o));
					idx = -1;
					for (int i = 0; i < sb[o].size(); i++)
						if (idx < 0 && sb[o][i].in_port == int'(got.source))
							idx = i;
					if (idx < 0) begin
						note_failure($sformatf("unexpected flit %h on output %0d", got, o));
					end else begin
						check_value("flit contents", got, sb[o][idx].flit);
						if (latency_check)
							check_value("latency", 32'(cycle - sb[o][idx].sent_cycle), 32'd2);
						sb[o].delete(idx);
					end
				end
			end
		end
	end

	// ##################################################
	// Test sequence
	initial begin
		coord_t dest_row [num_ports];
		coord_t dest_col [num_ports];
		void'($urandom(32'h1c58d3b0));
		reset    <= 1'b1;
		flit_in  <= '0;
		valid_in <= '0;
		full_in  <= '0;

		// Outputs quiet in reset and just after
		for (int i = 0; i < 5; i++) begin
			@(posedge clk);
			if (i == 4)
				reset <= 1'b0;
			@(negedge clk);
			check_value("valid_out in reset", 32'(valid_out), 32'd0);
			check_value("full_out in reset", 32'(full_out), 32'd0);
		end
		finish_test("reset");

		// Local, west, east, north, south seen from row 1, column 1
		dest_row = '{2'd1, coord_t'($urandom), coord_t'($urandom), 2'd0,
			coord_t'(2 + $urandom % 2)};
		dest_col = '{2'd1, 2'd0, coord_t'(2 + $urandom % 2), 2'd1, 2'd1};
		latency_check = 1'b1;
		for (int c = 0; c < num_ports; c++) begin
			send_flit(0, make_flit(0, dest_row[c], dest_col[c]));
			wait_drain();
		end
		latency_check = 1'b0;
		finish_test("latency and routing");

		// Every input to the east output
		fork
			send_stream(0, 4, 1'b0, 2'd3);
			send_stream(1, 4, 1'b0, 2'd3);
			send_stream(2, 4, 1'b0, 2'd3);
			send_stream(3, 4, 1'b0, 2'd3);
			send_stream(4, 4, 1'b0, 2'd3);
		join
		wait_drain();
		finish_test("contention");

		// East held full while the local queue fills with four flits
		held_port = int'(port_east);
		@(posedge clk);
		full_in[port_east] <= 1'b1;
		for (int j = 0; j < 4; j++) begin
			@(negedge clk);
			check_value("full_out before flit", 32'(full_out[port_local]), 32'd0);
			send_flit(0, make_flit(0, coord_t'($urandom), 2'd3));
		end
		@(negedge clk);
		check_value("full_out after four flits", 32'(full_out[port_local]), 32'd1);
		repeat (10) @(negedge clk);
		@(posedge clk);
		full_in[port_east] <= 1'b0;
		held_port = -1;
		wait_drain();
		finish_test("back-pressure");

		// Random traffic with random full_in pulses at about one in four
		traffic_done = 1'b0;
		fork
			begin
				fork
					send_stream(0, 24, 1'b1, 2'd0);
					send_stream(1, 24, 1'b1, 2'd0);
					send_stream(2, 24, 1'b1, 2'd0);
					send_stream(3, 24, 1'b1, 2'd0);
					send_stream(4, 24, 1'b1, 2'd0);
				join
				traffic_done = 1'b1;
			end
			begin
				while (!traffic_done) begin
					@(posedge clk);
					full_in <= port_mask_t'($urandom & $urandom);
				end
				@(posedge clk);
				full_in <= '0;
			end
		join
		wait_drain();
		finish_test("random traffic");

		$display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* src.f */
+incdir+include
verilog/router_cfg_pkg.sv
verilog/flit_pkg.sv
verilog/input_buffer.sv
verilog/route_alloc.sv
verilog/switch_traversal.sv
verilog/mesh_router.sv
dv/mesh_router_tb.sv

/* verilog/flit_pkg.sv */
// ##################################################
// Flit layout, single flit packets only
// Destination sits in the top bits, payload in the low bits
// ##################################################
package flit_pkg;

	import router_cfg_pkg::*;

	// Data carried by one flit
	typedef logic [19:0] payload_t;
	// Id of the router that sent the flit
	typedef logic [3:0] source_t;

	// Destination first so routing reads the top bits
	typedef struct packed {
		coord_t   dest_row;
		coord_t   dest_col;
		source_t  source;
		payload_t payload;
	} flit_t;

	// One flit per port, indexed by port_t
	typedef flit_t [num_ports-1:0] flit_bus_t;

endpackage

/* verilog/input_buffer.sv */
// ##################################################
// Show-ahead queue, buffer_depth a power of two, at least 2
// A write while full is dropped, upstream must watch full
// ##################################################
`timescale 1ns/1ps

module input_buffer
	import flit_pkg::*;
#(
	parameter int buffer_depth = 4
) (
	input  logic  clk,
	input  logic  reset,
	input  flit_t flit_in,
	input  logic  write,
	input  logic  pop,
	output flit_t head,
	output logic  head_valid,
	output logic  full
);

	localparam int ptr_w = $clog2(buffer_depth);

	// Queue index and occupancy
	typedef logic [ptr_w-1:0] ptr_t;
	typedef logic [ptr_w:0]   count_t;

	flit_t  mem [buffer_depth];
	ptr_t   wr_ptr;
	ptr_t   rd_ptr;
	count_t count;
	count_t count_next;
	logic   do_write;
	logic   do_pop;

	// Qualified write and pop, both may happen in one cycle
	assign do_write = write && !full;
	assign do_pop   = pop && head_valid;

	assign count_next = count + count_t'(do_write) - count_t'(do_pop);

	// Head shown ahead straight from storage
	assign head = mem[rd_ptr];

	// ##################################################
	// Pointers and flags
	// Pointers wrap on their own since depth is a power of two
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			head_valid <= 1'b0;
			full       <= 1'b0;
		end else begin
			if (do_write)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			count      <= count_next;
			// Flags come from the next count so they stay registered
			head_valid <= (count_next != '0);
			full       <= (count_next == count_t'(buffer_depth));
		end
	end

	// Flit storage
	always_ff @(posedge clk) begin
		if (do_write)
			mem[wr_ptr] <= flit_in;
	end

endmodule

/* verilog/mesh_router.sv */
// ##################################################
// Five-port mesh router, queue, allocate, then switch
// Uncontested latency is two cycles from valid_in to valid_out
// ##################################################
`timescale 1ns/1ps

module mesh_router
	import router_cfg_pkg::*;
	import flit_pkg::*;
#(
	parameter int         buffer_depth = 4,
	parameter route_alg_t route_alg    = route_xy
) (
	input  logic       clk,
	input  logic       reset,
	input  router_id_t router_id,
	input  flit_bus_t  flit_in,
	input  port_mask_t valid_in,
	output port_mask_t full_out,
	output flit_bus_t  flit_out,
	output port_mask_t valid_out,
	input  port_mask_t full_in
);

	// Queue heads and allocation results
	flit_bus_t             heads;
	port_mask_t            head_valid;
	port_mask_t            pop;
	port_t [num_ports-1:0] out_sel;
	port_mask_t            out_grant;

	// One input queue per port
	for (genvar p = 0; p < num_ports; p++) begin : g_in_port
		input_buffer #(
			.buffer_depth(buffer_depth)
		) input_buffer_i (
			.clk       (clk),
			.reset     (reset),
			.flit_in   (flit_in[p]),
			.write     (valid_in[p]),
			.pop       (pop[p]),
			.head      (heads[p]),
			.head_valid(head_valid[p]),
			.full      (full_out[p])
		);
	end

	// Route and arbitrate on the queue heads
	route_alloc #(
		.route_alg(route_alg)
	) route_alloc_i (
		.clk       (clk),
		.reset     (reset),
		.router_id (router_id),
		.heads     (heads),
		.head_valid(head_valid),
		.full_in   (full_in),
		.pop       (pop),
		.out_sel   (out_sel),
		.out_grant (out_grant)
	);

	// Register granted flits onto the outputs
	switch_traversal switch_traversal_i (
		.clk      (clk),
		.reset    (reset),
		.heads    (heads),
		.out_sel  (out_sel),
		.out_grant(out_grant),
		.flit_out (flit_out),
		.valid_out(valid_out)
	);

endmodule

/* verilog/route_alloc.sv */
// ##################################################
// Dimension-order routing and round-robin output arbiters
// Combinational apart from the arbiter pointers
// ##################################################
`timescale 1ns/1ps

module route_alloc
	import router_cfg_pkg::*;
	import flit_pkg::*;
#(
	parameter route_alg_t route_alg = route_xy
) (
	input  logic                    clk,
	input  logic                    reset,
	input  router_id_t              router_id,
	input  flit_bus_t               heads,
	input  port_mask_t              head_valid,
	input  port_mask_t              full_in,
	output port_mask_t              pop,
	output port_t [num_ports-1:0]   out_sel,
	output port_mask_t              out_grant
);

	coord_t cur_row;
	coord_t cur_col;
	port_t  route [num_ports];
	port_t  rr_ptr [num_ports];
	port_t  rr_ptr_next [num_ports];

	// Row in the upper half of the id, column in the lower half
	assign cur_row = router_id[$bits(router_id_t)-1 -: $bits(coord_t)];
	assign cur_col = router_id[$bits(coord_t)-1:0];

	// Output port for one destination
	function automatic port_t dor_route(input coord_t dest_row, input coord_t dest_col);
		port_t col_port;
		port_t row_port;
		begin
			col_port = (dest_col < cur_col) ? port_west : port_east;
			row_port = (dest_row < cur_row) ? port_north : port_south;
			if (route_alg == route_xy) begin
				// Columns first, then rows
				if (dest_col != cur_col)
					dor_route = col_port;
				else if (dest_row != cur_row)
					dor_route = row_port;
				else
					dor_route = port_local;
			end else begin
				// Rows first, then columns
				if (dest_row != cur_row)
					dor_route = row_port;
				else if (dest_col != cur_col)
					dor_route = col_port;
				else
					dor_route = port_local;
			end
		end
	endfunction

	// ##################################################
	// Route computation for every queue head
	always_comb begin
		for (int i = 0; i < num_ports; i++)
			route[i] = dor_route(heads[i].dest_row, heads[i].dest_col);
	end

	// ##################################################
	// Arbitration per output
	// Scan starts at the pointer, first requester wins
	always_comb begin
		int   idx;
		int   win;
		logic found;
		pop       = '0;
		out_grant = '0;
		for (int o = 0; o < num_ports; o++) begin
			found          = 1'b0;
			win            = 0;
			out_sel[o]     = port_local;
			rr_ptr_next[o] = rr_ptr[o];
			for (int k = 0; k < num_ports; k++) begin
				idx = (int'(rr_ptr[o]) + k) % num_ports;
				if (!found && head_valid[idx] && route[idx] == port_t'(o)) begin
					found = 1'b1;
					win   = idx;
				end
			end
			out_sel[o] = port_t'(win[2:0]);
			// A full downstream queue blocks the grant, head stays put
			if (found && !full_in[o]) begin
				out_grant[o]   = 1'b1;
				pop[win]       = 1'b1;
				rr_ptr_next[o] = port_t'(3'((win + 1) % num_ports));
			end
		end
	end

	// Pointers move past the winner only on a grant
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int o = 0; o < num_ports; o++)
				rr_ptr[o] <= port_local;
		end else begin
			for (int o = 0; o < num_ports; o++)
				rr_ptr[o] <= rr_ptr_next[o];
		end
	end

endmodule

/* verilog/router_cfg_pkg.sv */
// ##################################################
// Mesh geometry and port numbering for a 4x4 mesh
// Port order is fixed and every port bus is indexed by port_t
// ##################################################
package router_cfg_pkg;

	// One local port plus four neighbours
	parameter int num_ports = 5;
	// Rows and columns of the mesh
	parameter int mesh_dim = 4;

	// Row or column coordinate
	typedef logic [$clog2(mesh_dim)-1:0] coord_t;
	// Router position, row in the upper half and column in the lower half
	typedef logic [2*$clog2(mesh_dim)-1:0] router_id_t;
	// One bit per port
	typedef logic [num_ports-1:0] port_mask_t;

	// West and east move along columns, north and south along rows
	typedef enum logic [2:0] {
		port_local = 3'd0,
		port_west  = 3'd1,
		port_south = 3'd2,
		port_east  = 3'd3,
		port_north = 3'd4
	} port_t;

	// Dimension order of the route
	typedef enum logic {route_xy = 1'b0, route_yx = 1'b1} route_alg_t;

endpackage

/* verilog/switch_traversal.sv */
// ##################################################
// Registered crossbar, one flit per output per cycle
// ##################################################
`timescale 1ns/1ps

module switch_traversal
	import router_cfg_pkg::*;
	import flit_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  flit_bus_t             heads,
	input  port_t [num_ports-1:0] out_sel,
	input  port_mask_t            out_grant,
	output flit_bus_t             flit_out,
	output port_mask_t            valid_out
);

	// ##################################################
	// Output valids
	// Grant of this cycle becomes valid of the next
	always_ff @(posedge clk) begin
		if (reset)
			valid_out <= '0;
		else
			valid_out <= out_grant;
	end

	// ##################################################
	// Output flits
	// Selected head is captured every cycle, valid_out qualifies it
	always_ff @(posedge clk) begin
		for (int o = 0; o < num_ports; o++)
			flit_out[o] <= heads[out_sel[o]];
	end

endmodule
